// File: rv_isa_pkg.sv
// RV32I instruction encoding: opcodes, funct3 codes, format overlay
// and the instruction-type enum
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load/store access size, bit 2 marks unsigned loads
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_fmt_u;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N   // unknown opcode
    } inst_type_e;

endpackage

// File: core_pkg.sv
// core microarchitecture constants and ALU operation codes
package core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_AW    = 5;

    localparam logic [31:0] RESET_PC = 32'h8000_0000;   // first fetch address

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

// File: fetch_unit.sv
// program counter, instruction fetch sequencing and instruction register
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     imem_valid,
    input  logic [core_pkg::XLEN-1:0] imem_data,
    input  logic                     done,
    input  logic [core_pkg::XLEN-1:0] next_pc,
    output logic                     imem_req,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic [core_pkg::XLEN-1:0] inst,
    output logic                     inst_valid
);
    import core_pkg::*;

    typedef enum logic {
        S_FETCH,
        S_EXEC
    } state_e;

    state_e state;

    assign imem_addr = pc;   // pc only moves while no request is open

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_FETCH;
            pc         <= RESET_PC;
            imem_req   <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                S_FETCH: begin
                    if (imem_valid) begin
                        imem_req   <= 1'b0;
                        inst_valid <= 1'b1;   // decode window opens next cycle
                        state      <= S_EXEC;
                    end else begin
                        imem_req <= 1'b1;     // first fetch after reset
                    end
                end
                S_EXEC: begin
                    if (done) begin
                        pc       <= next_pc;
                        imem_req <= 1'b1;
                        state    <= S_FETCH;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // instruction register, held for the whole execute phase
    always_ff @(posedge clk) begin
        if (state == S_FETCH && imem_valid) begin
            inst <= imem_data;
        end
    end

endmodule

// File: inst_decoder.sv
// instruction decoder: format, register fields, immediates,
// ALU operation and control flags
`timescale 1ns/1ps

module inst_decoder (
    input  logic [core_pkg::XLEN-1:0] inst,
    output logic [2:0]                inst_type,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd,
    output logic [2:0]                funct3,
    output logic [core_pkg::XLEN-1:0] imm,
    output logic [3:0]                alu_op,
    output logic                      rd_we,
    output logic                      is_load,
    output logic                      is_store,
    output logic                      is_jal,
    output logic                      is_jalr,
    output logic                      is_lui
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    inst_fmt_u  w;
    inst_type_e ty;
    alu_op_e    op;
    logic [6:0] opcode;

    assign w      = inst;
    assign opcode = w.r_fmt.opcode;
    assign rs1    = w.r_fmt.rs1;
    assign rs2    = w.r_fmt.rs2;
    assign rd     = w.r_fmt.rd;
    assign funct3 = w.r_fmt.funct3;

    always_comb begin
        case (opcode)
            OP_REG:                   ty = TYPE_R;
            OP_IMM, OP_LOAD, OP_JALR: ty = TYPE_I;
            OP_STORE:                 ty = TYPE_S;
            OP_BRANCH:                ty = TYPE_B;
            OP_LUI, OP_AUIPC:         ty = TYPE_U;
            OP_JAL:                   ty = TYPE_J;
            default:                  ty = TYPE_N;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (ty)
            TYPE_I: imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
            TYPE_S: imm = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
            TYPE_B: imm = {{19{w.b_fmt.imm12}}, w.b_fmt.imm12, w.b_fmt.imm11,
                           w.b_fmt.imm10_5, w.b_fmt.imm4_1, 1'b0};
            TYPE_U: imm = {w.u_fmt.imm, 12'b0};
            TYPE_J: imm = {{11{w.j_fmt.imm20}}, w.j_fmt.imm20, w.j_fmt.imm19_12,
                           w.j_fmt.imm11, w.j_fmt.imm10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        op = ALU_ADD;   // address and link arithmetic
        if (opcode == OP_IMM || opcode == OP_REG) begin
            case (funct3)
                3'b000: op = (ty == TYPE_R && w.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: op = ALU_SLL;
                3'b010: op = ALU_SLT;
                3'b011: op = ALU_SLTU;
                3'b100: op = ALU_XOR;
                3'b101: op = w.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;  // imm[10] for SRAI
                3'b110: op = ALU_OR;
                default: op = ALU_AND;
            endcase
        end
    end

    assign inst_type = ty;
    assign alu_op    = op;
    assign rd_we     = (ty == TYPE_R) || (ty == TYPE_I) || (ty == TYPE_U) || (ty == TYPE_J);
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_jal    = (opcode == OP_JAL);
    assign is_jalr   = (opcode == OP_JALR);
    assign is_lui    = (opcode == OP_LUI);

endmodule

// File: reg_file.sv
// general register file, two read ports and one write port
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::REG_AW-1:0] raddr1,
    input  logic [core_pkg::REG_AW-1:0] raddr2,
    input  logic [core_pkg::REG_AW-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]   wdata,
    input  logic                        we,
    input  logic                        done,
    output logic [core_pkg::XLEN-1:0]   rdata1,
    output logic [core_pkg::XLEN-1:0]   rdata2
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (done && we && waddr != '0) begin
            regs[waddr] <= wdata;   // x0 stays at its reset value
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: alu.sv
// integer ALU, ten RV32I operations
`timescale 1ns/1ps

module alu (
    input  logic [core_pkg::XLEN-1:0] a,
    input  logic [core_pkg::XLEN-1:0] b,
    input  logic [3:0]                op,
    output logic [core_pkg::XLEN-1:0] result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

// File: exec_unit.sv
// execute stage: operand select, branch compare, next pc, result select
`timescale 1ns/1ps

module exec_unit (
    input  logic [2:0]                inst_type,
    input  logic [2:0]                funct3,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [3:0]                alu_op,
    input  logic                      is_jal,
    input  logic                      is_jalr,
    input  logic                      is_lui,
    output logic [core_pkg::XLEN-1:0] alu_result,
    output logic [core_pkg::XLEN-1:0] next_pc,
    output logic [core_pkg::XLEN-1:0] exec_result
);
    import rv_isa_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] pc_plus4;
    logic        taken;

    always_comb begin
        if (inst_type == TYPE_B || inst_type == TYPE_J || (inst_type == TYPE_U && !is_lui))
            op_a = pc;          // branch, jal, auipc
        else if (is_lui)
            op_a = '0;
        else
            op_a = rs1_data;
    end

    assign op_b = (inst_type == TYPE_R) ? rs2_data : imm;

    alu alu_inst (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb begin
        taken = 1'b0;
        if (inst_type == TYPE_B) begin
            case (funct3)
                F3_BEQ:  taken = (rs1_data == rs2_data);
                F3_BNE:  taken = (rs1_data != rs2_data);
                F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
                F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
                F3_BLTU: taken = (rs1_data < rs2_data);
                F3_BGEU: taken = (rs1_data >= rs2_data);
                default: taken = 1'b0;
            endcase
        end
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (taken || is_jal)
            next_pc = alu_result;
        else if (is_jalr)
            next_pc = {alu_result[31:1], 1'b0};
        else
            next_pc = pc_plus4;
    end

    assign exec_result = (is_jal || is_jalr) ? pc_plus4 : alu_result;   // link value

endmodule

// File: load_store_unit.sv
// data memory access: request sequencing, byte lanes, load extension
// and writeback data select
`timescale 1ns/1ps

module load_store_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  logic                      is_load,
    input  logic                      is_store,
    input  logic [2:0]                funct3,
    input  logic [core_pkg::XLEN-1:0] alu_result,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic [core_pkg::XLEN-1:0] exec_result,
    input  logic                      dmem_valid,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]                dmem_wmask,
    output logic                      done,
    output logic [core_pkg::XLEN-1:0] wb_data
);
    import rv_isa_pkg::*;

    logic        is_mem;
    logic [4:0]  lane_shift;
    logic [3:0]  size_mask;
    logic [31:0] rd_word;
    logic [31:0] load_data;

    assign is_mem     = is_load || is_store;
    assign lane_shift = {alu_result[1:0], 3'b000};

    // request opens the cycle after decode, closes after the response
    always_ff @(posedge clk) begin
        if (reset)
            dmem_req <= 1'b0;
        else if (dmem_req && dmem_valid)
            dmem_req <= 1'b0;
        else if (inst_valid && is_mem)
            dmem_req <= 1'b1;
    end

    assign done = (inst_valid && !is_mem) || (dmem_req && dmem_valid);

    assign dmem_addr = alu_result;
    assign dmem_we   = dmem_req && is_store;

    always_comb begin
        case (funct3)
            F3_B:    size_mask = 4'b0001;
            F3_H:    size_mask = 4'b0011;
            default: size_mask = 4'b1111;   // SW
        endcase
    end

    assign dmem_wdata = rs2_data << lane_shift;
    assign dmem_wmask = dmem_we ? (size_mask << alu_result[1:0]) : 4'b0000;

    // move the addressed lane down to bit 0, then extend
    assign rd_word = dmem_rdata >> lane_shift;

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{rd_word[7]}}, rd_word[7:0]};
            F3_H:    load_data = {{16{rd_word[15]}}, rd_word[15:0]};
            F3_BU:   load_data = {24'b0, rd_word[7:0]};
            F3_HU:   load_data = {16'b0, rd_word[15:0]};
            F3_W:    load_data = rd_word;
            default: load_data = rd_word;
        endcase
    end

    assign wb_data = is_load ? load_data : exec_result;

endmodule

// File: core_top.sv
// RV32I multi-cycle core top level, unit interconnect only
`timescale 1ns/1ps

module core_top (
    input  logic        clk,
    input  logic        reset,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_valid,
    input  logic [31:0] imem_data,
    output logic        dmem_req,
    output logic        dmem_we,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic [3:0]  dmem_wmask,
    input  logic        dmem_valid,
    input  logic [31:0] dmem_rdata
);
    // fetch / sequencing
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_valid;
    logic [31:0] next_pc;
    logic        done;

    // decode
    logic [2:0]  inst_type;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] imm;
    logic [3:0]  alu_op;
    logic        rd_we;
    logic        is_load;
    logic        is_store;
    logic        is_jal;
    logic        is_jalr;
    logic        is_lui;

    // operands and results
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic [31:0] exec_result;
    logic [31:0] wb_data;

    fetch_unit fetch_unit_inst (.*);

    inst_decoder inst_decoder_inst (.*);

    reg_file reg_file_inst (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (rd),
        .wdata  (wb_data),
        .we     (rd_we),
        .done   (done),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit exec_unit_inst (.*);

    load_store_unit load_store_unit_inst (.*);

endmodule

// File: core_asserts.sv
// protocol checks on the core's memory ports, bound into core_top
`timescale 1ns/1ps

module core_asserts (
    input logic       clk,
    input logic       reset,
    input logic       imem_req,
    input logic       imem_valid,
    input logic       dmem_req,
    input logic       dmem_we,
    input logic [3:0] dmem_wmask
);

    // fetch request held until answered
    imem_req_hold: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req)
        else $error("imem_req dropped before imem_valid");

    one_port_busy: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && dmem_req))
        else $error("imem_req and dmem_req high together");

    wmask_on_read: assert property (@(posedge clk) disable iff (reset)
        !dmem_we |-> dmem_wmask == 4'b0000)
        else $error("dmem_wmask set without dmem_we");

    // registered requests settle one edge into reset
    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !imem_req && !dmem_req)
        else $error("request high during reset");

endmodule

bind core_top core_asserts core_asserts_inst (.*);

// File: tb_core.sv
// core_top testbench with file-driven program image,
// random-latency memory model and store record checking
`timescale 1ns/1ps

module tb_core;

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_data;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wmask;
    logic        dmem_valid;
    logic [31:0] dmem_rdata;

    logic [31:0] mem [logic [31:0]];    // word address -> word
    bit          prog_addr [logic [31:0]];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];
    int          exp_idx;
    int          errors;
    logic [31:0] lfsr;
    bit          busy;
    int          wait_cnt;
    bit          first_fetch;

    core_top core_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic load_program();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the program file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", tag, a, d, m);
                if (tag == "I") begin
                    mem[a >> 2] = d;
                    prog_addr[a] = 1'b1;
                end else if (tag == "E") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_mask.push_back(m[3:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // memory model with 1 to 4 cycles of latency per request
    always @(posedge clk) begin
        logic [31:0] word;
        if (reset) begin
            imem_valid <= 1'b0;
            dmem_valid <= 1'b0;
            busy       <= 1'b0;
        end else if (imem_valid || dmem_valid) begin
            imem_valid <= 1'b0;   // request drops on this edge
            dmem_valid <= 1'b0;
        end else if ((imem_req || dmem_req) && !busy) begin
            lfsr = lfsr_step(lfsr);
            wait_cnt = lfsr[0];
            lfsr = lfsr_step(lfsr);
            wait_cnt = wait_cnt + 2 * lfsr[0];
            busy <= 1'b1;
            if (imem_req && first_fetch) begin
                check_value("imem_addr", imem_addr, 32'h8000_0000);
                first_fetch = 1'b0;
            end
        end else if (busy && wait_cnt > 0) begin
            wait_cnt--;
        end else if (busy) begin
            busy <= 1'b0;
            if (imem_req) begin
                if (!prog_addr.exists(imem_addr)) begin
                    $display("core fetched outside the program at %h", imem_addr);
                    errors++;
                end
                imem_data  <= mem.exists(imem_addr >> 2) ? mem[imem_addr >> 2] : 32'h0;
                imem_valid <= 1'b1;
            end else begin
                word = mem.exists(dmem_addr >> 2) ? mem[dmem_addr >> 2] : 32'h0;
                if (dmem_we) begin
                    if (exp_idx >= exp_addr.size()) begin
                        $display("store to %h with no expected record left", dmem_addr);
                        errors++;
                    end else begin
                        // records hold the word address, the mask gives the lane
                        check_value("dmem_addr", {dmem_addr[31:2], 2'b00},
                                    exp_addr[exp_idx]);
                        check_value("dmem_wmask", dmem_wmask, exp_mask[exp_idx]);
                        check_value("dmem_wdata", dmem_wdata & lane_bits(dmem_wmask),
                                    exp_data[exp_idx] & lane_bits(exp_mask[exp_idx]));
                        exp_idx++;
                    end
                    mem[dmem_addr >> 2] = (word & ~lane_bits(dmem_wmask)) |
                                          (dmem_wdata & lane_bits(dmem_wmask));
                end
                dmem_rdata <= word;
                dmem_valid <= 1'b1;
            end
        end
    end

    initial begin
        int cycles;
        reset       = 1'b1;
        imem_valid  = 1'b0;
        imem_data   = 32'h0;
        dmem_valid  = 1'b0;
        dmem_rdata  = 32'h0;
        lfsr        = 32'hf6f9e0b3;
        errors      = 0;
        exp_idx     = 0;
        wait_cnt    = 0;
        busy        = 1'b0;
        first_fetch = 1'b1;
        load_program();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (exp_idx < exp_addr.size() && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_idx < exp_addr.size()) begin
            $display("timeout with %0d of %0d store records matched",
                     exp_idx, exp_addr.size());
            errors++;
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: program_input.txt
# I <byte address> <instruction word>
# E <store address> <lane-aligned data> <byte mask>
I 80000000 000010b7
I 80000004 ffb00113
I 80000008 00c00193
I 8000000c 40310233
I 80000010 0040a023
I 80000014 40115293
I 80000018 0050a223
I 8000001c 0021b333
I 80000020 00000397
I 80000024 00734333
I 80000028 0060a423
I 8000002c 00314463
I 80000030 00100413
I 80000034 00240413
I 80000038 0021f463
I 8000003c 00440413
I 80000040 008004ef
I 80000044 01040413
I 80000048 0080a623
I 8000004c 0090a823
I 80000050 00208aa3
I 80000054 00309b23
I 80000058 01508503
I 8000005c 0150c583
I 80000060 00a0ac23
I 80000064 00b0ae23
I 80000068 00700013
I 8000006c 0200a023
I 80000070 0000006f
E 00001000 ffffffef f
E 00001004 fffffffd f
E 00001008 80000021 f
E 0000100c 00000006 f
E 00001010 80000044 f
E 00001014 0000fb00 2
E 00001014 000c0000 c
E 00001018 fffffffb f
E 0000101c 000000fb f
E 00001020 00000000 f

// File: filelist.f
rv_isa_pkg.sv
core_pkg.sv
fetch_unit.sv
inst_decoder.sv
reg_file.sv
alu.sv
exec_unit.sv
load_store_unit.sv
core_top.sv
core_asserts.sv
tb_core.sv
